/* project.f */
+incdir+dv
hdl/rv_isa_pkg.sv
hdl/cpu_bus_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/exec_unit.sv
hdl/load_store_unit.sv
hdl/data_ram.sv
hdl/cpu_top.sv
dv/cpu_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module cpu_tb -f project.f -Mdir obj_dir -o cpu_tb

# Pass only when the log holds the pass line
run: build
	./obj_dir/cpu_tb | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module cpu_tb -f project.f

clean:
	rm -rf obj_dir $(LOG)

/* dv/cpu_tb_checks.svh */
`ifndef CPU_TB_CHECKS_SVH
`define CPU_TB_CHECKS_SVH

int error_count = 0;  // Failed compares over the whole run
int test_count  = 0;

task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string name);
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

// Retire record, taken when valid is already seen
task automatic check_retire(input retire_t got, input retire_t exp);
    check_word(got.pc, exp.pc, "retire_o.pc");
    if (got.rd !== exp.rd) begin
        error_count++;
        $display("[ERROR] retire_o.rd got 0x%02h expected 0x%02h", got.rd, exp.rd);
    end
    check_word(got.wdata, exp.wdata, "retire_o.wdata");
endtask

// One line per finished test
task automatic report_test(input string name, input int errors_before);
    string verdict;
    test_count++;
    if (error_count == errors_before) begin
        verdict = "PASS";
    end else begin
        verdict = "FAIL";
    end
    $display("test %0d %s: %s", test_count, name, verdict);
endtask

`endif

/* dv/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb
    import cpu_bus_pkg::*;
;

    localparam int IMEM_WORDS     = 64;
    localparam int DMEM_WORDS     = 64;
    localparam int IDX_W          = $clog2(IMEM_WORDS);
    localparam int RESET_CYCLES   = 16;
    localparam int RETIRE_TIMEOUT = 10;  // Cycles per instruction

    typedef struct {
        logic [XLEN-1:0] instr;
        retire_t         exp;
        int              gap;  // Cycles since the previous retire
    } row_t;

    logic             clk = 1'b0;
    logic             reset_i;
    logic             imem_we_i;
    logic [IDX_W-1:0] imem_addr_i;
    logic [XLEN-1:0]  imem_data_i;
    retire_t          retire_o;
    logic [XLEN-1:0]  a0_o;

    row_t            rows[$];
    logic [XLEN-1:0] image [IMEM_WORDS];  // Instruction memory contents
    logic [XLEN-1:0] a0_exp;
    integer          seed;
    logic            timed_out;

    `include "cpu_tb_checks.svh"

    cpu_top #(
        .IMEM_WORDS ( IMEM_WORDS ),
        .DMEM_WORDS ( DMEM_WORDS )
    ) cpu_top_inst (
        .clk         ( clk ),
        .reset_i     ( reset_i ),
        .imem_we_i   ( imem_we_i ),
        .imem_addr_i ( imem_addr_i ),
        .imem_data_i ( imem_data_i ),
        .retire_o    ( retire_o ),
        .a0_o        ( a0_o )
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] reg_op_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                                logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                                logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [XLEN-1:0] sign_extend_12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic add_row(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] instr,
                           input logic [4:0] rd, input logic [XLEN-1:0] wdata, input int gap);
        row_t row;
        row.instr = instr;
        row.exp   = '{valid: 1'b1, pc: pc, rd: rd, wdata: wdata};
        row.gap   = gap;
        rows.push_back(row);
        image[pc[IDX_W+1:2]] = instr;
    endtask

    task automatic build_program();
        logic [XLEN-1:0] rnd_a;
        logic [XLEN-1:0] rnd_b;
        logic [XLEN-1:0] x13_exp;
        logic [XLEN-1:0] x14_exp;
        for (int a = 0; a < IMEM_WORDS; a++) begin
            image[a] = addi_word(5'd10, 5'd0, 12'(a));  // Skipped slots tag a0 with their index
        end
        rnd_a   = $random(seed);
        rnd_b   = $random(seed);
        x13_exp = sign_extend_12(rnd_a[11:0]);
        x14_exp = x13_exp + sign_extend_12(rnd_b[11:0]);
        a0_exp  = x14_exp + 32'd2;

        add_row(32'd0,   addi_word(5'd1, 5'd0, 12'd5), 5'd1, 32'h0000_0005, 1);
        add_row(32'd4,   addi_word(5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd, 1);  // -3
        add_row(32'd8,   reg_op_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0002, 1);
        add_row(32'd12,  reg_op_word(7'h20, 3'b000, 5'd4, 5'd2, 5'd1), 5'd4, 32'hffff_fff8, 1);
        add_row(32'd16,  reg_op_word(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), 5'd5, 32'h0000_0005, 1);
        add_row(32'd20,  reg_op_word(7'h00, 3'b110, 5'd6, 5'd1, 5'd2), 5'd6, 32'hffff_fffd, 1);
        add_row(32'd24,  reg_op_word(7'h00, 3'b100, 5'd7, 5'd1, 5'd2), 5'd7, 32'hffff_fff8, 1);
        add_row(32'd28,  reg_op_word(7'h00, 3'b010, 5'd8, 5'd2, 5'd1), 5'd8, 32'h0000_0001, 1);
        add_row(32'd32,  reg_op_word(7'h00, 3'b010, 5'd9, 5'd1, 5'd2), 5'd9, 32'h0000_0000, 1);
        add_row(32'd36,  lui_word(5'd11, 20'h12345), 5'd11, 32'h1234_5000, 1);
        add_row(32'd40,  addi_word(5'd0, 5'd1, 12'd7), 5'd0, 32'h0000_000c, 1);  // x0 stays 0
        add_row(32'd44,  reg_op_word(7'h00, 3'b000, 5'd12, 5'd0, 5'd1), 5'd12, 32'h5, 1);
        add_row(32'd48,  addi_word(5'd13, 5'd0, rnd_a[11:0]), 5'd13, x13_exp, 1);
        add_row(32'd52,  addi_word(5'd14, 5'd13, rnd_b[11:0]), 5'd14, x14_exp, 1);
        add_row(32'd56,  sw_word(5'd3, 5'd0, 12'd8), 5'd0, 32'h0, 2);
        add_row(32'd60,  lw_word(5'd15, 5'd0, 12'd8), 5'd15, 32'h0000_0002, 2);
        add_row(32'd64,  branch_word(3'b000, 5'd1, 5'd12, 13'd8), 5'd0, 32'h0, 1);  // Taken
        add_row(32'd72,  branch_word(3'b000, 5'd1, 5'd2, 13'd8), 5'd0, 32'h0, 1);   // Not taken
        add_row(32'd76,  branch_word(3'b001, 5'd1, 5'd2, 13'd12), 5'd0, 32'h0, 1);  // BNE taken
        add_row(32'd88,  jal_word(5'd16, 21'd16), 5'd16, 32'd92, 1);
        add_row(32'd104, reg_op_word(7'h00, 3'b000, 5'd10, 5'd14, 5'd15), 5'd10, a0_exp, 1);
        add_row(32'd108, jal_word(5'd0, 21'd0), 5'd0, 32'd112, 1);  // Spins here
    endtask

    task automatic wait_retire(output int cycles, output logic late);
        cycles = 0;
        late   = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_o.valid && cycles < RETIRE_TIMEOUT);
        if (!retire_o.valid) begin
            late = 1'b1;
            $display("Timeout: no instruction retired within %0d cycles", RETIRE_TIMEOUT);
        end
    endtask

    initial begin
        int gap;
        int errors_before;
        reset_i     = 1'b1;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;
        seed        = 32'h99a2913f;
        timed_out   = 1'b0;
        build_program();

        // Instruction memory only takes writes while reset is high
        for (int i = 0; i <= int'(rows[rows.size()-1].exp.pc >> 2); i++) begin
            @(posedge clk);
            imem_we_i   <= 1'b1;
            imem_addr_i <= IDX_W'(i);
            imem_data_i <= image[i];
        end
        @(posedge clk);
        imem_we_i <= 1'b0;

        errors_before = error_count;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_flag(retire_o.valid, 1'b0, "retire_o.valid");
            check_word(a0_o, '0, "a0_o");
        end
        report_test("reset", errors_before);
        @(posedge clk);
        reset_i <= 1'b0;

        for (int t = 0; t < rows.size(); t++) begin
            wait_retire(gap, timed_out);
            if (timed_out) begin
                break;
            end
            errors_before = error_count;
            check_retire(retire_o, rows[t].exp);
            check_word(gap, rows[t].gap, "retire gap cycles");
            report_test($sformatf("pc 0x%08h", rows[t].exp.pc), errors_before);
        end

        if (!timed_out) begin
            errors_before = error_count;
            check_word(a0_o, a0_exp, "a0_o");
            report_test("a0 after program", errors_before);
        end

        $display("Summary: %0d tests, %0d errors", test_count, error_count);
        if (!timed_out && error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
    import rv_isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          imem_we_i,    // Program load, honoured in reset
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  logic [XLEN-1:0]               imem_data_i,
    output retire_t                       retire_o,
    output logic [XLEN-1:0]               a0_o
);

    logic [XLEN-1:0] pc;
    instr_u          instr;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] store_data;
    logic            branch_taken;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] load_data;
    logic            stall;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch_unit_inst (
        .clk            ( clk ),
        .reset_i        ( reset_i ),
        .stall_i        ( stall ),
        .branch_taken_i ( branch_taken ),
        .jump_i         ( ctrl.jump ),
        .imm_i          ( imm ),
        .imem_we_i      ( imem_we_i ),
        .imem_addr_i    ( imem_addr_i ),
        .imem_data_i    ( imem_data_i ),
        .pc_o           ( pc ),
        .instr_o        ( instr )
    );

    decoder decoder_inst (
        .instr_i ( instr ),
        .ctrl_o  ( ctrl ),
        .imm_o   ( imm )
    );

    exec_unit exec_unit_inst (
        .clk            ( clk ),
        .reset_i        ( reset_i ),
        .stall_i        ( stall ),
        .instr_i        ( instr ),
        .ctrl_i         ( ctrl ),
        .imm_i          ( imm ),
        .pc_i           ( pc ),
        .load_data_i    ( load_data ),
        .alu_out_o      ( alu_out ),
        .store_data_o   ( store_data ),
        .branch_taken_o ( branch_taken ),
        .wdata_o        ( wdata ),
        .a0_o           ( a0_o )
    );

    load_store_unit load_store_unit_inst (
        .clk          ( clk ),
        .reset_i      ( reset_i ),
        .ctrl_i       ( ctrl ),
        .addr_i       ( alu_out ),
        .store_data_i ( store_data ),
        .wb_req_o     ( wb_req ),
        .wb_rsp_i     ( wb_rsp ),
        .load_data_o  ( load_data ),
        .stall_o      ( stall )
    );

    data_ram #(.DMEM_WORDS(DMEM_WORDS)) data_ram_inst (
        .clk      ( clk ),
        .reset_i  ( reset_i ),
        .wb_req_i ( wb_req ),
        .wb_rsp_o ( wb_rsp )
    );

    // An instruction completes in any running cycle without an open access
    always_comb begin
        retire_o.valid = !reset_i && !stall;
        retire_o.pc    = pc;
        retire_o.rd    = ctrl.reg_write ? instr.r.rd : 5'd0;  // Stores and branches report x0
        retire_o.wdata = wdata;
    end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import cpu_bus_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic    clk,
    input  logic    reset_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]  mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic [XLEN-1:0]  rdata_q;
    logic             access;

    assign idx = wb_req_i.adr[IDX_W+1:2];  // Word index, byte offset dropped

    // Skipping the cycle after ack makes every access a fresh request
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= mem[idx];
            if (wb_req_i.we) begin
                mem[idx] <= wb_req_i.dat;
            end
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
    import cpu_bus_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  ctrl_t           ctrl_i,
    input  logic [XLEN-1:0] addr_i,        // From the ALU
    input  logic [XLEN-1:0] store_data_i,
    output wb_req_t         wb_req_o,
    input  wb_rsp_t         wb_rsp_i,
    output logic [XLEN-1:0] load_data_o,
    output logic            stall_o
);

    logic req;
    logic pending_q;  // Request issued, ack not yet seen
    logic ack_ok;

    // No accesses while the core is held in reset
    assign req = (ctrl_i.mem_read || ctrl_i.mem_write) && !reset_i;

    // Only an ack that answers an issued request closes the access
    assign ack_ok = wb_rsp_i.ack && pending_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= req && !ack_ok;
        end
    end

    // Request fields follow the held instruction, so they stay stable until ack
    always_comb begin
        wb_req_o.cyc = req;
        wb_req_o.stb = req;
        wb_req_o.we  = ctrl_i.mem_write;
        wb_req_o.adr = addr_i;
        wb_req_o.dat = store_data_i;
    end

    assign load_data_o = wb_rsp_i.dat;   // Valid with ack
    assign stall_o     = req && !ack_ok;

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import rv_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,         // Blocks write-back until ack
    input  instr_u          instr_i,
    input  ctrl_t           ctrl_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] load_data_i,
    output logic [XLEN-1:0] alu_out_o,       // Also the data address
    output logic [XLEN-1:0] store_data_o,
    output logic            branch_taken_o,
    output logic [XLEN-1:0] wdata_o,         // Zero when nothing is written
    output logic [XLEN-1:0] a0_o
);

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            eq;

    // x0 is never written, so it keeps its reset value of zero
    assign rs1_val = regs[instr_i.r.rs1];
    assign rs2_val = regs[instr_i.r.rs2];
    assign op_b    = ctrl_i.alu_src_imm ? imm_i : rs2_val;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:    alu_out_o = rs1_val + op_b;
            ALU_SUB:    alu_out_o = rs1_val - op_b;
            ALU_AND:    alu_out_o = rs1_val & op_b;
            ALU_OR:     alu_out_o = rs1_val | op_b;
            ALU_XOR:    alu_out_o = rs1_val ^ op_b;
            ALU_SLT:    alu_out_o = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            ALU_PASS_B: alu_out_o = op_b;
            default:    alu_out_o = '0;
        endcase
    end

    assign eq             = (rs1_val == rs2_val);
    assign branch_taken_o = ctrl_i.branch && (eq ^ ctrl_i.branch_ne);  // BNE inverts
    assign store_data_o   = rs2_val;

    always_comb begin
        case (ctrl_i.result_src)
            RES_MEM:  result = load_data_i;
            RES_LINK: result = pc_i + 32'd4;
            default:  result = alu_out_o;
        endcase
    end

    assign wdata_o = ctrl_i.reg_write ? result : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs <= '{default: '0};
        end else if (ctrl_i.reg_write && !stall_i && instr_i.r.rd != 5'd0) begin
            regs[instr_i.r.rd] <= result;
        end
    end

    assign a0_o = regs[10];  // x10 kept visible at the top

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder
    import rv_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  instr_u          instr_i,
    output ctrl_t           ctrl_o,
    output logic [XLEN-1:0] imm_o
);

    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_s_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_j_type;

    // Each immediate read through the format view that owns it
    assign imm_i_type = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_s_type = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
    assign imm_b_type = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                         instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u_type = {instr_i.u.imm_31_12, 12'b0};
    assign imm_j_type = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                         instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    always_comb begin
        ctrl_o            = '0;  // Unknown encodings fall through as no-ops
        ctrl_o.alu_op     = ALU_ADD;
        ctrl_o.result_src = RES_ALU;
        imm_o             = '0;

        case (instr_i.r.opcode)
            OP_REG: begin
                ctrl_o.reg_write = 1'b1;
                case (instr_i.r.funct3)
                    F3_ADD_SUB: begin
                        if (instr_i.r.funct7 == F7_SUB) begin
                            ctrl_o.alu_op = ALU_SUB;
                        end else if (instr_i.r.funct7 != F7_BASE) begin
                            ctrl_o.reg_write = 1'b0;
                        end
                    end
                    F3_SLT:  ctrl_o.alu_op = ALU_SLT;
                    F3_XOR:  ctrl_o.alu_op = ALU_XOR;
                    F3_OR:   ctrl_o.alu_op = ALU_OR;
                    F3_AND:  ctrl_o.alu_op = ALU_AND;
                    default: ctrl_o.reg_write = 1'b0;  // Shifts and SLTU not supported
                endcase
            end
            OP_IMM: begin
                imm_o = imm_i_type;
                if (instr_i.i.funct3 == F3_ADD_SUB) begin  // ADDI only
                    ctrl_o.reg_write   = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                end
            end
            OP_LUI: begin
                imm_o              = imm_u_type;
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = ALU_PASS_B;
            end
            OP_LOAD: begin
                imm_o = imm_i_type;
                if (instr_i.i.funct3 == F3_WORD) begin
                    ctrl_o.reg_write   = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                    ctrl_o.mem_read    = 1'b1;
                    ctrl_o.result_src  = RES_MEM;
                end
            end
            OP_STORE: begin
                imm_o = imm_s_type;
                if (instr_i.s.funct3 == F3_WORD) begin
                    ctrl_o.alu_src_imm = 1'b1;
                    ctrl_o.mem_write   = 1'b1;
                end
            end
            OP_BRANCH: begin
                imm_o = imm_b_type;
                if (instr_i.b.funct3 == F3_BEQ || instr_i.b.funct3 == F3_BNE) begin
                    ctrl_o.branch    = 1'b1;
                    ctrl_o.branch_ne = (instr_i.b.funct3 == F3_BNE);
                end
            end
            OP_JAL: begin
                imm_o             = imm_j_type;
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.jump       = 1'b1;
                ctrl_o.result_src = RES_LINK;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import rv_isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          stall_i,         // Memory access still open
    input  logic                          branch_taken_i,
    input  logic                          jump_i,
    input  logic [XLEN-1:0]               imm_i,           // Branch or jump offset
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  logic [XLEN-1:0]               imem_data_i,
    output logic [XLEN-1:0]               pc_o,
    output instr_u                        instr_o
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] next_pc;

    // Program load port, open only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset_i && imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    always_comb begin
        if (branch_taken_i || jump_i) begin
            next_pc = pc_q + imm_i;  // PC relative target
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (!stall_i) begin
            pc_q <= next_pc;
        end
    end

    assign pc_o    = pc_q;
    assign instr_o = imem[pc_q[IDX_W+1:2]];  // Word addressed fetch

endmodule

/* hdl/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    import rv_isa_pkg::*;

    localparam int XLEN = 32;  // Data and address width of RV32I

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_LINK  // PC+4 for JAL
    } result_src_e;

    typedef struct packed {
        logic        reg_write;
        logic        alu_src_imm;  // Operand B from immediate
        alu_op_e     alu_op;
        result_src_e result_src;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        branch_ne;    // BNE rather than BEQ
        logic        jump;
    } ctrl_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
    } retire_t;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,  // ADD SUB AND OR XOR SLT
        OP_IMM    = 7'b0010011,  // ADDI
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,  // LW
        OP_STORE  = 7'b0100011,  // SW
        OP_BRANCH = 7'b1100011,  // BEQ BNE
        OP_JAL    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW width

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI passes the immediate through
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word, viewed through each encoding format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage
